// ==== design/capture_pkg.sv ====
package capture_pkg;

  localparam int NUM_LANES = 2;  // DDR byte lanes

  typedef logic [7:0]           byte_t;      // One lane of DQ
  typedef logic [15:0]          word_t;      // Falling byte above rising byte
  typedef logic [31:0]          bus_t;       // Interleaved read word
  typedef logic [2:0]           tap_t;       // Strobe delay in clocks
  typedef logic [NUM_LANES-1:0] lane_en_t;   // One enable per lane
  typedef logic [1:0]           cfg_addr_t;  // Config register address

  // Register map
  localparam cfg_addr_t CFG_CTRL = 2'd0;
  localparam cfg_addr_t CFG_TAP  = 2'd1;

  // Control register layout
  //   bit 0    sample enable
  //   bits 2:1 lane enables
  // Sampling starts off with both lanes armed
  localparam logic [2:0] CTRL_RESET = 3'b110;

endpackage

// ==== design/capture_cfg_regs.sv ====
`timescale 1ns/1ps

module capture_cfg_regs (
  input  logic                   dly_dqs_proc,
  input  logic                   hresetn,
  input  logic                   cfg_wr,
  input  capture_pkg::cfg_addr_t cfg_addr,
  input  capture_pkg::byte_t     cfg_wdata,
  output logic                   sample_en,
  output capture_pkg::lane_en_t  lane_en,
  output capture_pkg::tap_t      dqs_tap
);

  logic [2:0]        ctrl_q;  // Lane enables and sample enable
  capture_pkg::tap_t tap_q;
  logic              wr_ctrl;
  logic              wr_tap;

  assign wr_ctrl = cfg_wr && (cfg_addr == capture_pkg::CFG_CTRL);
  assign wr_tap  = cfg_wr && (cfg_addr == capture_pkg::CFG_TAP);

  always_ff @(posedge dly_dqs_proc or negedge hresetn)
  begin
    if (!hresetn)
    begin
      ctrl_q <= capture_pkg::CTRL_RESET;
      tap_q  <= '0;
    end
    else
    begin
      if (wr_ctrl)
        ctrl_q <= cfg_wdata[2:0];
      if (wr_tap)
        tap_q <= cfg_wdata[2:0];  // Upper bits of the byte are don't care
    end
  end

  assign sample_en = ctrl_q[0];
  assign lane_en   = ctrl_q[2:1];
  assign dqs_tap   = tap_q;

endmodule

// ==== design/dqs_lane_capture.sv ====
`timescale 1ns/1ps

// NUM_TAPS must be at least 2
module dqs_lane_capture #(
  parameter int NUM_TAPS = 8
) (
  input  logic               dly_dqs_proc,
  input  logic               hresetn,
  input  logic               dqs,
  input  capture_pkg::byte_t dq,
  input  logic               rd_dqs_mask,
  input  logic               sample_en,
  input  logic               lane_en,
  input  capture_pkg::tap_t  dqs_tap,
  output capture_pkg::word_t word,
  output logic               word_strobe
);

  localparam int SEL_W = $clog2(NUM_TAPS);

  logic               dqs_gated;
  logic [NUM_TAPS-1:0] dqs_line;  // Stage 0 is the registered strobe
  logic [SEL_W-1:0]   tap_sel;
  logic               dqs_dly;
  logic               dqs_dly_q;
  logic               cap_en;
  logic               edge_rise;
  logic               edge_fall;
  capture_pkg::byte_t dq_q;
  capture_pkg::byte_t low_byte;

  // Strobe only counts inside the read window
  assign dqs_gated = dqs & rd_dqs_mask;

  always_ff @(posedge dly_dqs_proc or negedge hresetn)
  begin
    if (!hresetn)
      dqs_line <= '0;
    else
      dqs_line <= {dqs_line[NUM_TAPS-2:0], dqs_gated};
  end

  // DQ sits one register behind the pins, like stage 0 of the strobe
  always_ff @(posedge dly_dqs_proc)
  begin
    dq_q <= dq;
  end

  // Taps past the end of the line clamp to the last stage
  always_comb
  begin
    if (int'(dqs_tap) >= NUM_TAPS - 1)
      tap_sel = SEL_W'(NUM_TAPS - 1);
    else
      tap_sel = SEL_W'(dqs_tap);
  end

  assign dqs_dly = dqs_line[tap_sel];

  always_ff @(posedge dly_dqs_proc or negedge hresetn)
  begin
    if (!hresetn)
      dqs_dly_q <= 1'b0;
    else
      dqs_dly_q <= dqs_dly;  // Tracks even while disabled
  end

  assign cap_en    = sample_en & lane_en;
  assign edge_rise = cap_en & dqs_dly & ~dqs_dly_q;
  assign edge_fall = cap_en & ~dqs_dly & dqs_dly_q;

  always_ff @(posedge dly_dqs_proc)
  begin
    if (edge_rise)
      low_byte <= dq_q;
    if (edge_fall)
      word <= {dq_q, low_byte};  // Falling byte goes on top
  end

  always_ff @(posedge dly_dqs_proc or negedge hresetn)
  begin
    if (!hresetn)
      word_strobe <= 1'b0;
    else
      word_strobe <= edge_fall;  // One pulse per completed word
  end

endmodule

// ==== design/read_word_bank.sv ====
`timescale 1ns/1ps

module read_word_bank #(
  parameter int BANK_DEPTH = 3
) (
  input  logic               dly_dqs_proc,
  input  logic               hresetn,
  input  capture_pkg::word_t word0,
  input  logic               word_strobe0,
  input  capture_pkg::word_t word1,
  input  logic               word_strobe1,
  input  logic               rd_start,
  input  logic               rd_pop,
  input  logic               rd_end,
  output capture_pkg::bus_t  rd_data
);

  localparam int PTR_W = (BANK_DEPTH > 1) ? $clog2(BANK_DEPTH) : 1;
  localparam logic [PTR_W-1:0] LAST = PTR_W'(BANK_DEPTH - 1);

  capture_pkg::word_t lane_word   [2];
  logic               lane_strobe [2];
  capture_pkg::word_t lane_out    [2];
  logic [PTR_W-1:0]   ring_ptr    [2];
  logic [PTR_W-1:0]   sel;

  assign lane_word[0]   = word0;
  assign lane_word[1]   = word1;
  assign lane_strobe[0] = word_strobe0;
  assign lane_strobe[1] = word_strobe1;

  for (genvar g = 0; g < 2; g++)
  begin : g_lane
    capture_pkg::word_t entry [BANK_DEPTH];

    // Write ring, rd_start pins it to slot 0
    always_ff @(posedge dly_dqs_proc or negedge hresetn)
    begin
      if (!hresetn)
        ring_ptr[g] <= '0;
      else if (rd_start)
        ring_ptr[g] <= '0;
      else if (lane_strobe[g])
        ring_ptr[g] <= (ring_ptr[g] == LAST) ? '0 : ring_ptr[g] + 1'b1;
    end

    // Unread entries are overwritten without notice
    always_ff @(posedge dly_dqs_proc or negedge hresetn)
    begin
      if (!hresetn)
      begin
        for (int i = 0; i < BANK_DEPTH; i++)
          entry[i] <= '0;
      end
      else if (lane_strobe[g])
      begin
        if (rd_start)
          entry[0] <= lane_word[g];
        else
          entry[ring_ptr[g]] <= lane_word[g];
      end
    end

    assign lane_out[g] = entry[sel];
  end

  // Shared read select
  always_ff @(posedge dly_dqs_proc or negedge hresetn)
  begin
    if (!hresetn)
      sel <= '0;
    else if (rd_end)
      sel <= '0;  // Wins over a pop in the same cycle
    else if (rd_pop)
      sel <= (sel == LAST) ? '0 : sel + 1'b1;
  end

  // High bytes in the upper half, lane 1 above lane 0 in each half
  assign rd_data = {lane_out[1][15:8], lane_out[0][15:8],
                    lane_out[1][7:0],  lane_out[0][7:0]};

endmodule

// ==== design/read_capture_top.sv ====
`timescale 1ns/1ps

module read_capture_top #(
  parameter int NUM_TAPS   = 8,
  parameter int BANK_DEPTH = 3
) (
  input  logic                                dly_dqs_proc,
  input  logic                                hresetn,
  input  logic                                cfg_wr,
  input  capture_pkg::cfg_addr_t              cfg_addr,
  input  capture_pkg::byte_t                  cfg_wdata,
  input  logic [capture_pkg::NUM_LANES-1:0]   dqs,
  input  capture_pkg::word_t                  dq,  // Lane 0 in the low byte
  input  logic                                rd_dqs_mask,
  input  logic                                rd_start,
  input  logic                                rd_pop,
  input  logic                                rd_end,
  output capture_pkg::bus_t                   rd_data
);

  logic                  sample_en;
  capture_pkg::lane_en_t lane_en;
  capture_pkg::tap_t     dqs_tap;
  capture_pkg::word_t    lane_word   [capture_pkg::NUM_LANES];
  logic                  lane_strobe [capture_pkg::NUM_LANES];

  capture_cfg_regs i_cfg (
    .dly_dqs_proc (dly_dqs_proc),
    .hresetn      (hresetn),
    .cfg_wr       (cfg_wr),
    .cfg_addr     (cfg_addr),
    .cfg_wdata    (cfg_wdata),
    .sample_en    (sample_en),
    .lane_en      (lane_en),
    .dqs_tap      (dqs_tap)
  );

  for (genvar g = 0; g < capture_pkg::NUM_LANES; g++)
  begin : g_lane
    dqs_lane_capture #(
      .NUM_TAPS (NUM_TAPS)
    ) i_lane (
      .dly_dqs_proc (dly_dqs_proc),
      .hresetn      (hresetn),
      .dqs          (dqs[g]),
      .dq           (dq[8*g +: 8]),
      .rd_dqs_mask  (rd_dqs_mask),  // One mask shared by both lanes
      .sample_en    (sample_en),
      .lane_en      (lane_en[g]),
      .dqs_tap      (dqs_tap),
      .word         (lane_word[g]),
      .word_strobe  (lane_strobe[g])
    );
  end

  read_word_bank #(
    .BANK_DEPTH (BANK_DEPTH)
  ) i_bank (
    .dly_dqs_proc (dly_dqs_proc),
    .hresetn      (hresetn),
    .word0        (lane_word[0]),
    .word_strobe0 (lane_strobe[0]),
    .word1        (lane_word[1]),
    .word_strobe1 (lane_strobe[1]),
    .rd_start     (rd_start),
    .rd_pop       (rd_pop),
    .rd_end       (rd_end),
    .rd_data      (rd_data)
  );

endmodule

// ==== testbench/read_capture_properties.sv ====
`timescale 1ns/1ps

module read_capture_properties #(
  parameter int BANK_DEPTH = 3,
  parameter int PTR_W      = 2
) (
  input logic              dly_dqs_proc,
  input logic              hresetn,
  input logic              rd_start,
  input logic              rd_end,
  input logic [PTR_W-1:0]  sel,
  input logic [PTR_W-1:0]  ring_ptr0,
  input logic [PTR_W-1:0]  ring_ptr1,
  input capture_pkg::bus_t rd_data
);

  a_sel_range : assert property (@(posedge dly_dqs_proc) disable iff (!hresetn)
    sel < BANK_DEPTH)
    else $error("Read select left the bank range");

  a_end_clears_sel : assert property (@(posedge dly_dqs_proc) disable iff (!hresetn)
    rd_end |=> sel == '0)
    else $error("Read select not cleared after rd_end");

  // Both write rings restart together
  a_start_rings : assert property (@(posedge dly_dqs_proc) disable iff (!hresetn)
    rd_start |=> (ring_ptr0 == '0) && (ring_ptr1 == '0))
    else $error("Write ring not at slot 0 after rd_start");

  a_reset_empty : assert property (@(posedge dly_dqs_proc)
    $rose(hresetn) |-> rd_data == '0)
    else $error("Read data not zero after reset release");

endmodule

bind read_word_bank read_capture_properties #(
  .BANK_DEPTH (BANK_DEPTH),
  .PTR_W      (PTR_W)
) i_props (
  .dly_dqs_proc (dly_dqs_proc),
  .hresetn      (hresetn),
  .rd_start     (rd_start),
  .rd_end       (rd_end),
  .sel          (sel),
  .ring_ptr0    (ring_ptr[0]),
  .ring_ptr1    (ring_ptr[1]),
  .rd_data      (rd_data)
);

// ==== testbench/tb_read_capture.sv ====
`timescale 1ns/1ps

module tb_read_capture;

  localparam int NUM_TAPS   = 8;
  localparam int BANK_DEPTH = 3;
  localparam int IDLE       = NUM_TAPS + 4;  // Drains the delay line
  localparam int MAX_CYC    = 80;
  localparam int WATCHDOG   = 5000;          // Clock cycles for the whole run

  logic                   dly_dqs_proc;
  logic                   hresetn;
  logic                   cfg_wr;
  capture_pkg::cfg_addr_t cfg_addr;
  capture_pkg::byte_t     cfg_wdata;
  logic [1:0]             dqs;
  capture_pkg::word_t     dq;
  logic                   rd_dqs_mask;
  logic                   rd_start;
  logic                   rd_pop;
  logic                   rd_end;
  capture_pkg::bus_t      rd_data;

  // Reference model state
  capture_pkg::word_t    m_bank  [2][BANK_DEPTH];
  int                    m_ring  [2];
  int                    m_sel;
  logic                  m_sample;
  capture_pkg::lane_en_t m_lane_en;
  capture_pkg::tap_t     m_tap;
  capture_pkg::word_t    m_words [2][8];  // Words completed in the last burst
  int                    m_count [2];

  logic                  lvl     [2][MAX_CYC];  // Strobe level per burst cycle
  capture_pkg::byte_t    dq_hist [2][MAX_CYC];
  int                    burst_len;

  logic [31:0] rng;
  string       cur_test;
  int          test_errs;
  int          err_total;
  int          tests_run;
  int          tests_failed;

  read_capture_top #(
    .NUM_TAPS   (NUM_TAPS),
    .BANK_DEPTH (BANK_DEPTH)
  ) i_dut (
    .dly_dqs_proc (dly_dqs_proc),
    .hresetn      (hresetn),
    .cfg_wr       (cfg_wr),
    .cfg_addr     (cfg_addr),
    .cfg_wdata    (cfg_wdata),
    .dqs          (dqs),
    .dq           (dq),
    .rd_dqs_mask  (rd_dqs_mask),
    .rd_start     (rd_start),
    .rd_pop       (rd_pop),
    .rd_end       (rd_end),
    .rd_data      (rd_data)
  );

  initial
  begin
    dly_dqs_proc = 1'b0;
    forever #10 dly_dqs_proc = ~dly_dqs_proc;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    rng = xorshift32(rng);
    return lo + int'(rng % (hi - lo + 1));
  endfunction

  function automatic logic [31:0] rand_bits();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // Lane 0 owns bytes 2 and 0 of the bus
  function automatic capture_pkg::word_t lane_half(input capture_pkg::bus_t b, input int lane);
    if (lane == 0)
      return {b[23:16], b[7:0]};
    return {b[31:24], b[15:8]};
  endfunction

  function automatic capture_pkg::bus_t expected_bus(input int s);
    return {m_bank[1][s][15:8], m_bank[0][s][15:8], m_bank[1][s][7:0], m_bank[0][s][7:0]};
  endfunction

  task automatic check_bus(input string what, input capture_pkg::bus_t exp,
                           input capture_pkg::bus_t act);
    if (act !== exp)
    begin
      $display("ERROR %s %s: expected %h actual %h", cur_test, what, exp, act);
      test_errs++;
      err_total++;
    end
  endtask

  task automatic check_word(input string what, input capture_pkg::word_t exp,
                            input capture_pkg::word_t act);
    if (act !== exp)
    begin
      $display("ERROR %s %s: expected %h actual %h", cur_test, what, exp, act);
      test_errs++;
      err_total++;
    end
  endtask

  task automatic step();
    @(posedge dly_dqs_proc);
    @(negedge dly_dqs_proc);
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errs == 0)
      $display("PASS %s", cur_test);
    else
    begin
      $display("FAIL %s with %0d mismatches", cur_test, test_errs);
      tests_failed++;
    end
  endtask

  task automatic write_cfg(input capture_pkg::cfg_addr_t addr, input capture_pkg::byte_t data);
    cfg_wr    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    step();
    cfg_wr    = 1'b0;
  endtask

  // Low lead-in, then a high and a low phase per word
  function automatic int build_schedule(input int lane, input int words);
    int pos;
    int len;
    pos = rand_range(2, 4);
    for (int w = 0; w < words; w++)
    begin
      len = rand_range(2, 4);
      for (int i = 0; i < len; i++)
      begin
        lvl[lane][pos] = 1'b1;
        pos++;
      end
      pos = pos + rand_range(2, 4);
    end
    return pos;
  endfunction

  // Applies the capture rules to the recorded burst
  task automatic apply_burst_model(input logic mask);
    logic               prev;
    logic               cur;
    int                 eff_tap;
    capture_pkg::byte_t low;
    eff_tap = (int'(m_tap) >= NUM_TAPS - 1) ? NUM_TAPS - 1 : int'(m_tap);
    for (int l = 0; l < 2; l++)
    begin
      prev       = 1'b0;
      low        = '0;
      m_count[l] = 0;
      for (int k = 0; k < burst_len; k++)
      begin
        cur = lvl[l][k] & mask;
        if (cur != prev && m_sample && m_lane_en[l])
        begin
          if (cur)
            low = dq_hist[l][k + eff_tap];
          else
          begin
            m_bank[l][m_ring[l]] = {dq_hist[l][k + eff_tap], low};
            m_words[l][m_count[l]] = {dq_hist[l][k + eff_tap], low};
            m_count[l]++;
            m_ring[l] = (m_ring[l] + 1) % BANK_DEPTH;
          end
        end
        prev = cur;
      end
    end
  endtask

  task automatic run_burst(input int words, input logic mask);
    int n0;
    int n1;
    for (int c = 0; c < MAX_CYC; c++)
    begin
      lvl[0][c] = 1'b0;
      lvl[1][c] = 1'b0;
    end
    n0 = build_schedule(0, words);
    n1 = build_schedule(1, words);
    burst_len = (n0 > n1) ? n0 : n1;
    rd_start    = 1'b1;
    rd_dqs_mask = mask;  // Both strobes low here, so no false edge
    dqs         = 2'b00;
    dq          = capture_pkg::word_t'(rand_bits());
    step();
    rd_start  = 1'b0;
    m_ring[0] = 0;
    m_ring[1] = 0;
    for (int c = 0; c < burst_len + IDLE; c++)
    begin
      dqs           = {lvl[1][c], lvl[0][c]};
      dq            = capture_pkg::word_t'(rand_bits());
      dq_hist[0][c] = dq[7:0];
      dq_hist[1][c] = dq[15:8];
      step();
    end
    rd_dqs_mask = 1'b1;
    apply_burst_model(mask);
  endtask

  // Reads every entry once, then one more to see the wrap
  task automatic read_back(input bit by_lane);
    string what;
    rd_end = 1'b1;
    rd_pop = 1'b1;  // End has priority
    step();
    rd_end = 1'b0;
    rd_pop = 1'b0;
    m_sel  = 0;
    for (int r = 0; r <= BANK_DEPTH; r++)
    begin
      what = $sformatf("read %0d entry %0d", r, m_sel);
      if (by_lane)
      begin
        check_word({what, " lane 0"}, m_bank[0][m_sel], lane_half(rd_data, 0));
        check_word({what, " lane 1"}, m_bank[1][m_sel], lane_half(rd_data, 1));
      end
      else
        check_bus(what, expected_bus(m_sel), rd_data);
      rd_pop = 1'b1;
      step();
      rd_pop = 1'b0;
      m_sel  = (m_sel + 1) % BANK_DEPTH;
    end
  endtask

  initial
  begin
    capture_pkg::tap_t tap;
    int                off_lane;
    hresetn      = 1'b0;
    cfg_wr       = 1'b0;
    cfg_addr     = '0;
    cfg_wdata    = '0;
    dqs          = 2'b00;
    dq           = '0;
    rd_dqs_mask  = 1'b1;
    rd_start     = 1'b0;
    rd_pop       = 1'b0;
    rd_end       = 1'b0;
    rng          = 32'd8;
    err_total    = 0;
    tests_run    = 0;
    tests_failed = 0;
    m_sample     = 1'b0;
    m_lane_en    = 2'b11;
    m_tap        = '0;
    m_sel        = 0;
    for (int l = 0; l < 2; l++)
    begin
      m_ring[l] = 0;
      for (int i = 0; i < BANK_DEPTH; i++)
        m_bank[l][i] = '0;
    end

    for (int i = 0; i < 16; i++)
      @(negedge dly_dqs_proc);
    hresetn = 1'b1;
    step();

    start_test("reset_and_sampling_off");
    check_bus("after reset", '0, rd_data);
    run_burst(3, 1'b1);
    read_back(1'b0);
    end_test();

    start_test("three_words_tap0");
    write_cfg(capture_pkg::CFG_CTRL, 8'h07);
    m_sample  = 1'b1;
    m_lane_en = 2'b11;
    run_burst(3, 1'b1);
    read_back(1'b0);
    end_test();

    start_test("random_taps");
    for (int n = 0; n < 4; n++)
    begin
      tap = capture_pkg::tap_t'(rand_range(1, 7));
      write_cfg(capture_pkg::CFG_TAP, {5'(rand_bits()), tap});  // Junk in 7:3
      m_tap = tap;
      run_burst(rand_range(1, 3), 1'b1);
      read_back(1'b0);
    end
    end_test();

    start_test("overwrite_round_robin");
    tap = capture_pkg::tap_t'(rand_range(0, 7));
    write_cfg(capture_pkg::CFG_TAP, {5'b0, tap});
    m_tap = tap;
    run_burst(rand_range(4, 5), 1'b1);
    rd_end = 1'b1;
    step();
    rd_end = 1'b0;
    check_word("entry 0 lane 0 fourth word", m_words[0][3], lane_half(rd_data, 0));
    check_word("entry 0 lane 1 fourth word", m_words[1][3], lane_half(rd_data, 1));
    read_back(1'b0);
    end_test();

    start_test("lane_disabled");
    off_lane  = rand_range(0, 1);
    m_lane_en = (off_lane == 0) ? 2'b10 : 2'b01;
    write_cfg(capture_pkg::CFG_CTRL, {5'b0, m_lane_en, 1'b1});
    run_burst(3, 1'b1);
    read_back(1'b1);
    end_test();

    start_test("strobe_masked");
    m_lane_en = 2'b11;
    write_cfg(capture_pkg::CFG_CTRL, 8'h07);
    run_burst(3, 1'b0);
    read_back(1'b1);
    end_test();

    $display("Tests run %0d, failed %0d, mismatches %0d", tests_run, tests_failed, err_total);
    if (err_total == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

  // Stops a run that never reaches its end
  initial
  begin : watchdog
    for (int i = 0; i < WATCHDOG; i++)
      @(posedge dly_dqs_proc);
    $display("Timeout: the test sequence did not complete within %0d cycles", WATCHDOG);
    $display("Finished with errors");
    $finish;
  end

endmodule

// ==== verilog.f ====
design/capture_pkg.sv
design/capture_cfg_regs.sv
design/dqs_lane_capture.sv
design/read_word_bank.sv
design/read_capture_top.sv
testbench/read_capture_properties.sv
testbench/tb_read_capture.sv

// ==== Bender.yml ====
package:
  name: read_capture

sources:
  - files:
      - design/capture_pkg.sv
      - design/capture_cfg_regs.sv
      - design/dqs_lane_capture.sv
      - design/read_word_bank.sv
      - design/read_capture_top.sv
  - target: test
    files:
      - testbench/read_capture_properties.sv
      - testbench/tb_read_capture.sv
